/* common/exs_pkg.sv */
package exs_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and register file size
	////////////////////////////////////////////////////////////////////////////

	// Operand width
	localparam int data_w = 32;

	// Architectural registers, r0 is hardwired to zero
	localparam int reg_n = 16;
	localparam int reg_addr_w = $clog2(reg_n);

	typedef logic [data_w-1:0] data_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	////////////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////////////

	// ALU functions
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		op_sll = 3'd5,
		op_srl = 3'd6,
		op_slt = 3'd7
	} alu_op_e;

	// Operand source select, register file is the fallback
	typedef enum logic [1:0] {
		sel_rf  = 2'd0,
		sel_imm = 2'd1,
		sel_ex  = 2'd2,
		sel_wb  = 2'd3
	} opsel_e;

	////////////////////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////////////////////

	// Instruction as it arrives on the input stream
	typedef struct packed {
		alu_op_e   op;
		reg_addr_t rd;
		reg_addr_t ra;
		reg_addr_t rb;
		logic      use_imm;
		data_t     imm;
	} instr_t;

	// Result as it leaves on the output stream
	typedef struct packed {
		reg_addr_t rd;
		data_t     value;
	} result_t;

	// Per-stage tag, tells forwarding which destination is in flight
	typedef struct packed {
		logic      valid;
		alu_op_e   op;
		reg_addr_t rd;
	} stage_t;

	// ALU function, shared by the execute stage and the reference model
	function automatic data_t alu_calc(alu_op_e op, data_t a, data_t b);
		data_t res;
		case (op)
			op_add: res = a + b;
			op_sub: res = a - b;
			op_and: res = a & b;
			op_or:  res = a | b;
			op_xor: res = a ^ b;
			// Shift amount is the low 5 bits of B
			op_sll: res = a << b[4:0];
			op_srl: res = a >> b[4:0];
			// Signed compare gives 1 or 0
			op_slt: res = ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
			default: res = '0;
		endcase
		return res;
	endfunction

endpackage

/* hdl/reg_file.sv */
module reg_file import exs_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	// Read ports, combinational
	input  reg_addr_t ra_addr,
	input  reg_addr_t rb_addr,
	output data_t     ra_data,
	output data_t     rb_data,

	// Write port, from the execute register
	input  logic      we,
	input  reg_addr_t wr_addr,
	input  data_t     wr_data
);

	// Register array
	data_t regs [reg_n];

	////////////////////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////////////////////

	// Reset clears every register
	// r0 never takes a write
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_n; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////////////////////

	// No write-through here
	// A value written this edge is forwarded by the pipe instead
	always_comb begin
		ra_data = regs[ra_addr];
		rb_data = regs[rb_addr];
		// r0 reads zero whatever the array holds
		if (ra_addr == '0) begin
			ra_data = '0;
		end
		if (rb_addr == '0) begin
			rb_data = '0;
		end
	end

endmodule

/* hdl/forward_ctrl.sv */
module forward_ctrl import exs_pkg::*; (
	// Instruction waiting on the input stream
	input  instr_t in_instr,

	// In-flight destinations
	// op_dst belongs to the ALU output, ex_dst to the execute register
	input  stage_t op_dst,
	input  stage_t ex_dst,

	// Operand source selects
	output opsel_e sel_a,
	output opsel_e sel_b
);

	////////////////////////////////////////////////////////////////////////////
	// Hazard detection
	////////////////////////////////////////////////////////////////////////////

	// Source lookup for one register operand
	// Youngest producer wins, then the older one, then the register file
	function automatic opsel_e pick_src(reg_addr_t src, stage_t young, stage_t old);
		opsel_e sel;
		sel = sel_rf;
		// r0 is never forwarded, so a zero destination never matches
		if (src != '0) begin
			if (young.valid && (young.rd == src)) begin
				sel = sel_ex;
			end else if (old.valid && (old.rd == src)) begin
				sel = sel_wb;
			end
		end
		return sel;
	endfunction

	// Distance one hazards hit op_dst
	// Distance two hazards hit ex_dst
	logic hit_a_ex;
	logic hit_a_wb;

	assign hit_a_ex = (pick_src(in_instr.ra, op_dst, ex_dst) == sel_ex);
	assign hit_a_wb = (pick_src(in_instr.ra, op_dst, ex_dst) == sel_wb);

	////////////////////////////////////////////////////////////////////////////
	// Select outputs
	////////////////////////////////////////////////////////////////////////////

	// Operand A has no immediate leg
	always_comb begin
		if (hit_a_ex) begin
			sel_a = sel_ex;
		end else if (hit_a_wb) begin
			sel_a = sel_wb;
		end else begin
			sel_a = sel_rf;
		end
	end

	// Operand B takes the immediate ahead of any forward
	always_comb begin
		if (in_instr.use_imm) begin
			sel_b = sel_imm;
		end else begin
			sel_b = pick_src(in_instr.rb, op_dst, ex_dst);
		end
	end

endmodule

/* operand/operand_path.sv */
module operand_path import exs_pkg::*; #(
	// 1 keeps the immediate leg of the mux
	parameter bit has_imm = 1'b0
) (
	input  logic   clk,
	input  logic   rst_n,

	// Load when an instruction is accepted
	input  logic   load,
	// Whole pipe frozen by output back-pressure
	input  logic   stall,

	// Source select from forwarding control
	input  opsel_e sel,

	// Candidate sources
	input  data_t  rf_data,
	input  data_t  imm,
	input  data_t  ex_forw,
	input  data_t  wb_forw,

	// Operand register
	output data_t  operand
);

	// Mux output
	data_t muxed;
	// Immediate leg, folds back to the register file when absent
	data_t imm_leg;

	////////////////////////////////////////////////////////////////////////////
	// Immediate leg
	////////////////////////////////////////////////////////////////////////////

	generate
		if (has_imm) begin : g_imm
			assign imm_leg = imm;
		end else begin : g_no_imm
			// Operand A never sees sel_imm
			assign imm_leg = rf_data;
		end
	endgenerate

	////////////////////////////////////////////////////////////////////////////
	// Forwarding mux
	////////////////////////////////////////////////////////////////////////////

	// ex_forw is the ALU output of the instruction one ahead
	// wb_forw is the execute register, two ahead
	always_comb begin
		case (sel)
			sel_imm: muxed = imm_leg;
			sel_ex:  muxed = ex_forw;
			sel_wb:  muxed = wb_forw;
			default: muxed = rf_data;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Operand register
	////////////////////////////////////////////////////////////////////////////

	// Forward sources freeze with this register under stall
	// so a single load condition is enough
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			operand <= '0;
		end else if (load && !stall) begin
			operand <= muxed;
		end
	end

endmodule

/* hdl/execute_stage.sv */
module execute_stage import exs_pkg::*; #(
	parameter int data_w = exs_pkg::data_w
) (
	input  logic              clk,
	input  logic              rst_n,

	// Input stream
	input  logic              in_valid,
	input  instr_t            in_instr,
	output logic              in_ready,

	// Operands from the operand stage registers
	input  logic [data_w-1:0] a,
	input  logic [data_w-1:0] b,

	// Forward sources and their destinations
	output logic [data_w-1:0] ex_forw,
	output stage_t            op_dst,
	output logic [data_w-1:0] wb_forw,
	output stage_t            ex_dst,

	// Register file write
	output logic              rf_we,
	output reg_addr_t         rf_addr,
	output logic [data_w-1:0] rf_data,

	// Pipe freeze
	output logic              stall,

	// Output stream
	output logic              out_valid,
	input  logic              out_ready,
	output result_t           out_result
);

	// Operand stage tag
	stage_t op_q;
	// Execute stage tag and value
	stage_t ex_q;
	logic [data_w-1:0] ex_val;
	// Writeback valid
	logic wb_valid;
	// Combinational ALU output
	logic [data_w-1:0] alu_out;

	////////////////////////////////////////////////////////////////////////////
	// Handshake and stall
	////////////////////////////////////////////////////////////////////////////

	// Output held and not taken freezes every stage
	assign stall = out_valid && !out_ready;
	assign in_ready = !stall;

	////////////////////////////////////////////////////////////////////////////
	// Operand stage tag
	////////////////////////////////////////////////////////////////////////////

	// Operand values live in the operand paths
	// A gap on the input turns into a bubble here
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			op_q <= '0;
		end else if (!stall) begin
			op_q.valid <= in_valid;
			op_q.op <= in_instr.op;
			op_q.rd <= in_instr.rd;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////////////////////

	assign alu_out = alu_calc(op_q.op, a, b);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_q <= '0;
		end else if (!stall) begin
			ex_q <= op_q;
		end
	end

	// Result payload, no reset
	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_val <= alu_out;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Writeback
	////////////////////////////////////////////////////////////////////////////

	// Register file takes the execute value as it moves to writeback
	// r0 filtering happens inside the register file
	assign rf_we = ex_q.valid && !stall;
	assign rf_addr = ex_q.rd;
	assign rf_data = ex_val;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else if (!stall) begin
			wb_valid <= ex_q.valid;
		end
	end

	// Only real results touch the output payload
	always_ff @(posedge clk) begin
		if (!stall && ex_q.valid) begin
			out_result.rd <= ex_q.rd;
			out_result.value <= ex_val;
		end
	end

	assign out_valid = wb_valid;

	// Forwarding view of the pipe
	assign ex_forw = alu_out;
	assign op_dst = op_q;
	assign wb_forw = ex_val;
	assign ex_dst = ex_q;

endmodule

/* hdl/exec_slice_top.sv */
module exec_slice_top import exs_pkg::*; #(
	parameter int data_w = exs_pkg::data_w
) (
	input  logic    clk,
	input  logic    rst_n,

	// Instruction stream
	input  logic    in_valid,
	output logic    in_ready,
	input  instr_t  in_instr,

	// Result stream
	output logic    out_valid,
	input  logic    out_ready,
	output result_t out_result
);

	////////////////////////////////////////////////////////////////////////////
	// Interconnect
	////////////////////////////////////////////////////////////////////////////

	data_t ra_data;
	data_t rb_data;
	opsel_e sel_a;
	opsel_e sel_b;
	logic [data_w-1:0] opnd_a;
	logic [data_w-1:0] opnd_b;
	logic [data_w-1:0] ex_forw;
	logic [data_w-1:0] wb_forw;
	stage_t op_dst;
	stage_t ex_dst;
	logic rf_we;
	reg_addr_t rf_addr;
	logic [data_w-1:0] rf_data;
	logic stall;

	////////////////////////////////////////////////////////////////////////////
	// Operand stage
	////////////////////////////////////////////////////////////////////////////

	reg_file reg_file_i (
		.clk(clk),
		.rst_n(rst_n),
		.ra_addr(in_instr.ra),
		.rb_addr(in_instr.rb),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.we(rf_we),
		.wr_addr(rf_addr),
		.wr_data(rf_data)
	);

	forward_ctrl forward_ctrl_i (
		.in_instr(in_instr),
		.op_dst(op_dst),
		.ex_dst(ex_dst),
		.sel_a(sel_a),
		.sel_b(sel_b)
	);

	// Operand A, register sources only
	operand_path #(
		.has_imm(1'b0)
	) opnd_a_i (
		.clk(clk),
		.rst_n(rst_n),
		.load(in_valid),
		.stall(stall),
		.sel(sel_a),
		.rf_data(ra_data),
		.imm(in_instr.imm),
		.ex_forw(ex_forw),
		.wb_forw(wb_forw),
		.operand(opnd_a)
	);

	// Operand B, with the immediate leg
	operand_path #(
		.has_imm(1'b1)
	) opnd_b_i (
		.clk(clk),
		.rst_n(rst_n),
		.load(in_valid),
		.stall(stall),
		.sel(sel_b),
		.rf_data(rb_data),
		.imm(in_instr.imm),
		.ex_forw(ex_forw),
		.wb_forw(wb_forw),
		.operand(opnd_b)
	);

	////////////////////////////////////////////////////////////////////////////
	// Execute and writeback
	////////////////////////////////////////////////////////////////////////////

	execute_stage #(
		.data_w(data_w)
	) execute_stage_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_instr(in_instr),
		.in_ready(in_ready),
		.a(opnd_a),
		.b(opnd_b),
		.ex_forw(ex_forw),
		.op_dst(op_dst),
		.wb_forw(wb_forw),
		.ex_dst(ex_dst),
		.rf_we(rf_we),
		.rf_addr(rf_addr),
		.rf_data(rf_data),
		.stall(stall),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_result(out_result)
	);

endmodule

/* tests/exec_slice_checker.sv */
module exec_slice_checker import exs_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,

	// Input stream as seen by the DUT
	input  logic    in_valid,
	input  logic    in_ready,
	input  instr_t  in_instr,

	// Output stream as seen by the DUT
	input  logic    out_valid,
	input  logic    out_ready,
	input  result_t out_result,

	// Running counts for the testbench
	output int      errors,
	output int      checked,
	output int      pending
);

	// Reference register state, r0 stays zero
	data_t model_regs [reg_n];

	// Expected results in issue order, with acceptance cycle and stall count
	result_t exp_q [$];
	int acc_cyc_q [$];
	int acc_stall_q [$];

	// Edge counter and stalled-edge counter
	int cyc;
	int stalls;

	////////////////////////////////////////////////////////////////////////////
	// Reference ALU
	////////////////////////////////////////////////////////////////////////////

	function automatic data_t model_alu(alu_op_e op, data_t a, data_t b);
		data_t res;
		logic lt;
		// Signed less-than from the sign bits, then magnitude
		if (a[data_w-1] != b[data_w-1]) begin
			lt = a[data_w-1];
		end else begin
			lt = (a < b);
		end
		case (op)
			op_add: res = a + b;
			op_sub: res = a + ~b + data_t'(1);
			op_and: res = a & b;
			op_or:  res = a | b;
			op_xor: res = a ^ b;
			op_sll: res = a << b[4:0];
			op_srl: res = a >> b[4:0];
			default: res = {{(data_w-1){1'b0}}, lt};
		endcase
		return res;
	endfunction

	initial begin
		errors = 0;
		checked = 0;
		pending = 0;
		cyc = 0;
		stalls = 0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Issue side and compare side
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		data_t a;
		data_t b;
		result_t exp;
		int lat;
		int lat_exp;
		if (!rst_n) begin
			for (int i = 0; i < reg_n; i++) begin
				model_regs[i] = '0;
			end
		end else begin
			// Accepted instruction, executed in order against the model
			if (in_valid && in_ready) begin
				a = (in_instr.ra == '0) ? data_t'(0) : model_regs[in_instr.ra];
				if (in_instr.use_imm) begin
					b = in_instr.imm;
				end else begin
					b = (in_instr.rb == '0) ? data_t'(0) : model_regs[in_instr.rb];
				end
				exp.rd = in_instr.rd;
				exp.value = model_alu(in_instr.op, a, b);
				if (in_instr.rd != '0) begin
					model_regs[in_instr.rd] = exp.value;
				end
				exp_q.push_back(exp);
				acc_cyc_q.push_back(cyc);
				acc_stall_q.push_back(stalls);
			end
			// Output transfer, oldest expected result first
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("Output result at time %0t arrived with no instruction outstanding",
						$time);
					errors++;
				end else begin
					exp = exp_q.pop_front();
					lat = cyc - acc_cyc_q.pop_front();
					// Each stalled edge adds one cycle to the 3-cycle pipe
					lat_exp = 3 + stalls - acc_stall_q.pop_front();
					checked++;
					if (out_result !== exp) begin
						$display("** Error at %0t: got rd %0d value %h, expected rd %0d value %h",
							$time, out_result.rd, out_result.value, exp.rd, exp.value);
						errors++;
					end
					if (lat != lat_exp) begin
						$display("** Error at %0t: rd %0d took %0d cycles, expected %0d",
							$time, exp.rd, lat, lat_exp);
						errors++;
					end
				end
			end
			if (out_valid && !out_ready) begin
				stalls++;
			end
			cyc++;
			pending = exp_q.size();
		end
	end

endmodule

/* tests/exec_slice_asserts.sv */
module exec_slice_asserts import exs_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    in_ready,
	input  logic    out_valid,
	input  logic    out_ready,
	input  result_t out_result
);

	// Failure count, read by the testbench
	int fail_cnt;

	initial begin
		fail_cnt = 0;
	end

	// No output while reset is applied
	a_reset_idle: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else begin
			$error("out_valid high after a reset edge");
			fail_cnt++;
		end

	// Input ready is the inverse of the stall
	a_ready_stall: assert property (@(posedge clk) disable iff (!rst_n)
		in_ready == !(out_valid && !out_ready))
		else begin
			$error("in_ready does not match the stall condition");
			fail_cnt++;
		end

	// Held result stays put until taken
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_result)))
		else begin
			$error("out_result changed or was dropped while stalled");
			fail_cnt++;
		end

endmodule

bind exec_slice_top exec_slice_asserts asserts_i (
	.clk(clk),
	.rst_n(rst_n),
	.in_ready(in_ready),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_result(out_result)
);

/* tests/exec_slice_tb.sv */
module exec_slice_tb import exs_pkg::*; ();

	// Instruction counts per test
	localparam int n_t1 = 16;
	localparam int n_t2 = 64;
	localparam int n_t3 = 48;
	localparam int n_t4 = 48;
	localparam int n_t5 = 200;
	localparam int n_t6 = 24;
	localparam int n_total = n_t1 + n_t2 + n_t3 + n_t4 + n_t5 + n_t6;
	localparam int cycle_limit = 4 * n_total + 200;

	// One input slot per cycle, idle slots make gaps
	typedef struct packed {
		logic   idle;
		instr_t ins;
	} slot_t;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	instr_t in_instr;
	logic out_valid;
	logic out_ready;
	result_t out_result;

	integer seed;
	slot_t slot_q [$];
	// Random back-pressure on the output
	logic bp_mode;
	// Input transfer on the last rising edge
	logic fired;
	int cycles;
	int tb_errors;
	int tests_failed;
	int base;
	int chk_errors;
	int chk_checked;
	int chk_pending;
	reg_addr_t l1;
	reg_addr_t l2;
	reg_addr_t rd;

	exec_slice_top #(
		.data_w(data_w)
	) exec_slice_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_instr(in_instr),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_result(out_result)
	);

	exec_slice_checker result_check_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_instr(in_instr),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_result(out_result),
		.errors(chk_errors),
		.checked(chk_checked),
		.pending(chk_pending)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic int pick(int n);
		return ($random(seed) & 32'h7fffffff) % n;
	endfunction

	// Source register that avoids both in-flight destinations
	function automatic reg_addr_t free_src(reg_addr_t d1, reg_addr_t d2);
		reg_addr_t r;
		r = reg_addr_t'(pick(reg_n));
		while (r != '0 && (r == d1 || r == d2)) begin
			r = reg_addr_t'(pick(reg_n));
		end
		return r;
	endfunction

	task automatic push_instr(input alu_op_e op, input reg_addr_t d, input reg_addr_t ra,
		input reg_addr_t rb, input logic use_imm, input data_t imm);
		slot_t s;
		s.idle = 1'b0;
		s.ins.op = op;
		s.ins.rd = d;
		s.ins.ra = ra;
		s.ins.rb = rb;
		s.ins.use_imm = use_imm;
		s.ins.imm = imm;
		slot_q.push_back(s);
	endtask

	task automatic push_gap(input int n);
		slot_t s;
		s = '0;
		s.idle = 1'b1;
		repeat (n) slot_q.push_back(s);
	endtask

	function automatic int err_total();
		return tb_errors + chk_errors + exec_slice_top_i.asserts_i.fail_cnt;
	endfunction

	// Wait until every slot is sent and every result is out
	task automatic drain_pipe();
		while (slot_q.size() != 0 || in_valid) @(posedge clk);
		do @(negedge clk); while (chk_pending != 0);
	endtask

	task automatic report_test(input int num, input string name);
		int errs;
		errs = err_total() - base;
		if (errs == 0) begin
			$display("test %0d %s: passed", num, name);
		end else begin
			$display("test %0d %s: failed with %0d errors", num, name, errs);
			tests_failed++;
		end
		@(posedge clk);
		base = err_total();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Input driver and back-pressure, falling edge
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		fired = rst_n && in_valid && in_ready;
	end

	always @(negedge clk) begin
		slot_t s;
		out_ready = bp_mode ? (pick(100) >= 40) : 1'b1;
		// Hold the instruction until it is taken
		if (!in_valid || fired) begin
			if (slot_q.size() != 0) begin
				s = slot_q.pop_front();
				in_valid = !s.idle;
				in_instr = s.ins;
			end else begin
				in_valid = 1'b0;
			end
		end
	end

	// Run limit from the total instruction count
	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run stopped after %0d cycles with %0d results still missing",
				cycles, chk_pending);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		out_ready = 1'b1;
		seed = 32'h9697;
		bp_mode = 1'b0;
		fired = 1'b0;
		cycles = 0;
		tb_errors = 0;
		tests_failed = 0;
		l1 = '0;
		l2 = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(posedge clk);
		base = 0;

		// Idle state, then every register read back as zero
		if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
			$display("** Error at %0t: after reset out_valid %b in_ready %b, expected 0 and 1",
				$time, out_valid, in_ready);
			tb_errors++;
		end
		for (int i = 0; i < n_t1; i++) begin
			push_instr(op_add, reg_addr_t'(i), reg_addr_t'(i), '0, 1'b1, '0);
		end
		drain_pipe();
		report_test(1, "reset state and zero registers");

		// No source matches either of the two previous destinations
		for (int i = 0; i < n_t2; i++) begin
			rd = reg_addr_t'(1 + pick(reg_n - 1));
			push_instr(alu_op_e'(i % 8), rd, free_src(l1, l2), free_src(l1, l2),
				logic'(pick(2)), data_t'($random(seed)));
			l2 = l1;
			l1 = rd;
		end
		drain_pipe();
		report_test(2, "independent instructions");

		// Distance one on A, on B, then on both
		for (int i = 0; i < n_t3; i++) begin
			rd = reg_addr_t'(1 + pick(reg_n - 1));
			case (i % 3)
				0: push_instr(alu_op_e'(pick(8)), rd, l1, reg_addr_t'(pick(reg_n)), 1'b0, '0);
				1: push_instr(alu_op_e'(pick(8)), rd, reg_addr_t'(pick(reg_n)), l1, 1'b0, '0);
				default: push_instr(alu_op_e'(pick(8)), rd, l1, l1, 1'b0, '0);
			endcase
			l2 = l1;
			l1 = rd;
		end
		drain_pipe();
		report_test(3, "distance one forwarding");

		// Distance two, mixed distances, and a repeated destination for priority
		for (int i = 0; i < n_t4; i++) begin
			rd = reg_addr_t'(1 + pick(reg_n - 1));
			case (i % 4)
				0: push_instr(alu_op_e'(pick(8)), rd, l2, l2, 1'b0, '0);
				1: push_instr(alu_op_e'(pick(8)), rd, l1, l2, 1'b0, '0);
				2: begin
					rd = l1;
					push_instr(op_add, rd, l2, '0, 1'b1, data_t'($random(seed)));
				end
				default: push_instr(alu_op_e'(pick(8)), rd, l1, l1, 1'b0, '0);
			endcase
			l2 = l1;
			l1 = rd;
		end
		drain_pipe();
		report_test(4, "distance two forwarding and priority");

		// Random traffic with input gaps and output back-pressure
		bp_mode = 1'b1;
		for (int i = 0; i < n_t5; i++) begin
			push_instr(alu_op_e'(pick(8)), reg_addr_t'(pick(reg_n)),
				reg_addr_t'(pick(reg_n)), reg_addr_t'(pick(reg_n)), logic'(pick(2)),
				data_t'($random(seed)));
			if (pick(10) < 3) begin
				push_gap(1 + pick(3));
			end
		end
		drain_pipe();
		bp_mode = 1'b0;
		report_test(5, "back-pressure and gaps");

		// r0 write followed at once by an r0 read
		for (int i = 0; i < n_t6 / 2; i++) begin
			push_instr(op_add, '0, reg_addr_t'(pick(reg_n)), '0, 1'b1, data_t'($random(seed)));
			if (i % 2 == 0) begin
				push_instr(op_or, reg_addr_t'(1 + pick(reg_n - 1)), '0, '0, 1'b0, '0);
			end else begin
				push_instr(op_add, reg_addr_t'(1 + pick(reg_n - 1)), '0, '0, 1'b1, '0);
			end
		end
		drain_pipe();
		report_test(6, "register zero writes");

		$display("6 tests run, %0d passed, %0d failed, %0d results checked, %0d errors",
			6 - tests_failed, tests_failed, chk_checked, err_total());
		if (err_total() == 0 && tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
common/exs_pkg.sv
hdl/reg_file.sv
hdl/forward_ctrl.sv
operand/operand_path.sv
hdl/execute_stage.sv
hdl/exec_slice_top.sv
tests/exec_slice_checker.sv
tests/exec_slice_asserts.sv
tests/exec_slice_tb.sv
